// ==== compile.f ====
hw/mandel_pkg.sv
hw/escape_iterator.sv
hw/color_map.sv
hw/frame_walker.sv
hw/mandel_render_top.sv
testbench/tb_clock_gen.sv
testbench/mandel_assert.sv
testbench/mandel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mandel_tb -f compile.f \
	-o mandel_sim \
	&& ./obj_dir/mandel_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== testbench/mandel_tb.sv ====
`timescale 1ns/1ps

module mandel_tb;

	localparam int frame_width = 8;
	localparam int frame_height = 6;
	localparam int iter_max = 32;
	localparam int n_pix = frame_width * frame_height;
	localparam int n_frames = 3;
	localparam int aw = $clog2(n_pix);
	// Slowest pixel plus handshakes, with stalls on top
	localparam int frame_timeout = n_pix * (iter_max + 8) * 4;

	typedef logic signed [26:0] fx_t;

	// Band colours RRRGGGBB, band 0 first
	localparam logic [7:0] band_color [0:8] = '{
		8'b00000000, 8'b01100100, 8'b01100100, 8'b10101001, 8'b01100101,
		8'b00100101, 8'b01101010, 8'b01010010, 8'b01010010
	};

	logic clk;
	logic reset;
	logic start;
	fx_t x_start;
	fx_t y_start;
	fx_t pixel_increment;
	logic busy;
	logic frame_done;
	logic pixel_valid;
	logic pixel_ready;
	logic [aw-1:0] pixel_addr;
	logic [7:0] pixel_color;

	// Separate LFSR streams for coordinates and for ready
	logic [31:0] coord_lfsr;
	logic [31:0] ready_lfsr;

	// Colours seen on the pixel port, frames back to back
	logic [7:0] got_color [0:n_frames*n_pix-1];
	int xfer_total;
	int done_pulses;
	int port_errors;
	int value_errors;
	int timeout_errors;
	logic aborted;

	tb_clock_gen clk_gen_i (
		.clk(clk),
		.reset(reset)
	);

	mandel_render_top #(
		.frame_width(frame_width),
		.frame_height(frame_height),
		.iter_max(iter_max)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.pixel_increment(pixel_increment),
		.busy(busy),
		.frame_done(frame_done),
		.pixel_valid(pixel_valid),
		.pixel_ready(pixel_ready),
		.pixel_addr(pixel_addr),
		.pixel_color(pixel_color)
	);

	//////////////////////////////////////////////////////////////////////
	// Random numbers
	//////////////////////////////////////////////////////////////////////

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic take_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], s[0]};
			s = lfsr_next(s);
		end
	endtask

	// Corner in -2.0 .. +1.0, step between 1/16 and 1/8
	task automatic pick_coords(output fx_t xs, output fx_t ys, output fx_t inc);
		logic [31:0] r;
		take_bits(coord_lfsr, 25, r);
		xs = fx_t'(r % 32'd25165824) - 27'sd16777216;
		take_bits(coord_lfsr, 25, r);
		ys = fx_t'(r % 32'd25165824) - 27'sd16777216;
		take_bits(coord_lfsr, 19, r);
		inc = fx_t'(32'd524288 + {13'd0, r[18:0]});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// 54-bit product, sign then bits 48..23
	function automatic fx_t fx_mul(input fx_t a, input fx_t b);
		longint p;
		p = longint'(a) * longint'(b);
		return {p[53], p[48:23]};
	endfunction

	function automatic int escape_count(input fx_t cr, input fx_t ci);
		fx_t zr;
		fx_t zi;
		fx_t sq_re;
		fx_t sq_im;
		fx_t mag;
		fx_t nr;
		fx_t ni;
		int n;
		logic out;
		zr = '0;
		zi = '0;
		n = 0;
		out = 1'b0;
		while (!out) begin
			sq_re = fx_mul(zr, zr);
			sq_im = fx_mul(zi, zi);
			// All sums wrap at 27 bits
			mag = sq_re + sq_im;
			nr = sq_re - sq_im + cr;
			ni = (fx_mul(zr, zi) <<< 1) + ci;
			out = (int'(mag) > 33554432) || (n == iter_max)
				|| (int'(nr) > 16777216) || (int'(nr) < -16777216)
				|| (int'(ni) > 16777216) || (int'(ni) < -16777216);
			// Escaping step still counts
			zr = nr;
			zi = ni;
			n++;
		end
		return n;
	endfunction

	// First band whose lower bound is met
	function automatic logic [7:0] palette_color(input int n);
		for (int b = 0; b < 8; b++) begin
			if (n >= (iter_max >> b)) begin
				return band_color[b];
			end
		end
		return band_color[8];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Pixel port monitor and ready driver
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic held;
		logic [aw-1:0] held_addr;
		logic [7:0] held_color;
		logic [31:0] r;
		pixel_ready = 1'b0;
		ready_lfsr = 32'd3;
		xfer_total = 0;
		done_pulses = 0;
		port_errors = 0;
		held = 1'b0;
		held_addr = '0;
		held_color = '0;
		forever begin
			@(negedge clk);
			// Outputs here are what the next rising edge sees
			if (held && !(pixel_valid && pixel_addr == held_addr
				&& pixel_color == held_color)) begin
				port_errors++;
				$display("FAIL %0t: stalled pixel write changed or dropped", $time);
			end
			// Ready low one cycle in four
			take_bits(ready_lfsr, 2, r);
			pixel_ready = (r[1:0] != 2'b00);
			held = pixel_valid && !pixel_ready;
			held_addr = pixel_addr;
			held_color = pixel_color;
			if (pixel_valid && pixel_ready) begin
				if (xfer_total >= n_frames * n_pix) begin
					port_errors++;
					$display("FAIL %0t: pixel write beyond the last frame", $time);
				end else begin
					if (int'(pixel_addr) != xfer_total % n_pix) begin
						port_errors++;
						$display("FAIL %0t: address %0d, expected %0d", $time,
							pixel_addr, xfer_total % n_pix);
					end
					got_color[xfer_total] = pixel_color;
				end
				xfer_total++;
			end
			if (frame_done) begin
				if (xfer_total != (done_pulses + 1) * n_pix) begin
					port_errors++;
					$display("FAIL %0t: frame_done after %0d writes", $time, xfer_total);
				end
				done_pulses++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame stimulus and colour checks
	//////////////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		int n;
		fx_t xs;
		fx_t ys;
		fx_t inc;
		fx_t cre;
		fx_t cim;
		fx_t junk_x;
		fx_t junk_y;
		fx_t junk_inc;
		start = 1'b0;
		x_start = '0;
		y_start = '0;
		pixel_increment = '0;
		value_errors = 0;
		timeout_errors = 0;
		aborted = 1'b0;
		coord_lfsr = 32'd3;

		cycles = 0;
		while (reset && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (reset) begin
			timeout_errors++;
			$display("Timeout: reset was never released");
			aborted = 1'b1;
		end

		// Quiet outputs before any start
		for (int i = 0; i < 3 && !aborted; i++) begin
			@(negedge clk);
			if (busy || frame_done || pixel_valid) begin
				value_errors++;
				$display("FAIL %0t: busy, frame_done or pixel_valid high before start", $time);
			end
		end

		for (int f = 0; f < n_frames && !aborted; f++) begin
			pick_coords(xs, ys, inc);
			@(negedge clk);
			start = 1'b1;
			x_start = xs;
			y_start = ys;
			pixel_increment = inc;
			@(negedge clk);
			start = 1'b0;

			// Mid-frame start with other coordinates must be ignored
			cycles = 0;
			while (!(busy && pixel_addr >= aw'(10)) && cycles < frame_timeout) begin
				@(negedge clk);
				cycles++;
			end
			if (!(busy && pixel_addr >= aw'(10))) begin
				timeout_errors++;
				$display("Timeout: frame %0d never reached pixel 10", f);
				aborted = 1'b1;
			end else begin
				pick_coords(junk_x, junk_y, junk_inc);
				start = 1'b1;
				x_start = junk_x;
				y_start = junk_y;
				pixel_increment = junk_inc;
				@(negedge clk);
				start = 1'b0;
			end

			cycles = 0;
			while (!frame_done && cycles < frame_timeout && !aborted) begin
				@(negedge clk);
				cycles++;
			end
			if (!frame_done && !aborted) begin
				timeout_errors++;
				$display("Timeout: no frame_done in frame %0d", f);
				aborted = 1'b1;
			end

			// Raster walk of the model, row wrap steps y down
			cre = xs;
			cim = ys;
			for (int i = 0; i < n_pix && !aborted; i++) begin
				n = escape_count(cre, cim);
				if (got_color[f*n_pix+i] !== palette_color(n)) begin
					value_errors++;
					$display("FAIL %0t: frame %0d pixel %0d colour %b, expected %b (count %0d)",
						$time, f, i, got_color[f*n_pix+i], palette_color(n), n);
				end
				if (i % frame_width == frame_width - 1) begin
					cre = xs;
					cim = cim - inc;
				end else begin
					cre = cre + inc;
				end
			end
		end

		repeat (2) @(negedge clk);
		if (!aborted && done_pulses != n_frames) begin
			value_errors++;
			$display("FAIL %0t: %0d frame_done pulses, expected %0d", $time,
				done_pulses, n_frames);
		end

		@(posedge clk);
		$display("Errors: value %0d, port %0d, timeout %0d",
			value_errors, port_errors, timeout_errors);
		if (value_errors + port_errors + timeout_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== testbench/mandel_assert.sv ====
`timescale 1ns/1ps

module mandel_assert #(
	parameter int aw = 19
) (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic frame_done,
	input logic pixel_valid,
	input logic pixel_ready,
	input logic [aw-1:0] pixel_addr,
	input logic [7:0] pixel_color
);

	// Write held while the frame buffer stalls
	hold_check: assert property (@(posedge clk) disable iff (reset)
		(pixel_valid && !pixel_ready) |=>
			(pixel_valid && $stable(pixel_addr) && $stable(pixel_color)))
		else $error("pixel write changed during a stall");

	// Single-cycle pulse
	done_pulse_check: assert property (@(posedge clk) disable iff (reset)
		frame_done |=> !frame_done)
		else $error("frame_done longer than one cycle");

	// busy already low when done
	done_busy_check: assert property (@(posedge clk) disable iff (reset)
		!(frame_done && busy))
		else $error("frame_done and busy high together");

	// No writes outside a frame
	idle_write_check: assert property (@(posedge clk) disable iff (reset)
		!busy |-> !pixel_valid)
		else $error("pixel_valid high while not busy");

endmodule

bind mandel_render_top mandel_assert #(
	.aw($clog2(frame_width*frame_height))
) assert_i (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.frame_done(frame_done),
	.pixel_valid(pixel_valid),
	.pixel_ready(pixel_ready),
	.pixel_addr(pixel_addr),
	.pixel_color(pixel_color)
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period = 10,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic reset
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// Reset seen high on the first four rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== hw/mandel_render_top.sv ====
`timescale 1ns/1ps

module mandel_render_top import mandel_pkg::*; #(
	parameter int frame_width = 640,
	parameter int frame_height = 480,
	parameter int iter_max = 1000
) (
	input  logic clk,
	input  logic reset,

	// Frame request
	input  logic start,
	input  fix_t x_start,
	input  fix_t y_start,
	input  fix_t pixel_increment,
	output logic busy,
	output logic frame_done,

	// Pixel writes to the external frame buffer
	output logic pixel_valid,
	input  logic pixel_ready,
	output logic [$clog2(frame_width*frame_height)-1:0] pixel_addr,
	output color_t pixel_color
);

	//////////////////////////////////////////////////////////////////////
	// Renderer core
	//////////////////////////////////////////////////////////////////////

	// Single iterator lives inside the walker
	frame_walker #(
		.frame_width(frame_width),
		.frame_height(frame_height),
		.iter_max(iter_max)
	) walker_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.pixel_increment(pixel_increment),
		.busy(busy),
		.frame_done(frame_done),
		.pixel_valid(pixel_valid),
		.pixel_ready(pixel_ready),
		.pixel_addr(pixel_addr),
		.pixel_color(pixel_color)
	);

endmodule

// ==== hw/frame_walker.sv ====
`timescale 1ns/1ps

module frame_walker import mandel_pkg::*; #(
	parameter int frame_width = 640,
	parameter int frame_height = 480,
	parameter int iter_max = 1000
) (
	input  logic clk,
	input  logic reset,

	// Frame request
	input  logic start,
	input  fix_t x_start,
	input  fix_t y_start,
	input  fix_t pixel_increment,
	output logic busy,
	output logic frame_done,

	// Pixel write stream
	output logic pixel_valid,
	input  logic pixel_ready,
	output logic [$clog2(frame_width*frame_height)-1:0] pixel_addr,
	output color_t pixel_color
);

	localparam int cw = $clog2(iter_max) + 1;
	localparam int col_w = (frame_width > 1) ? $clog2(frame_width) : 1;
	localparam int row_w = (frame_height > 1) ? $clog2(frame_height) : 1;
	localparam logic [col_w-1:0] last_col = col_w'(frame_width - 1);
	localparam logic [row_w-1:0] last_row = row_w'(frame_height - 1);

	walk_state_t state;

	// Raster position
	logic [col_w-1:0] col;
	logic [row_w-1:0] row;
	logic last_pixel;

	// Frame settings and running coordinate
	fix_t x_start_q;
	fix_t inc_q;
	fix_t c_re;
	fix_t c_im;

	// Iterator link
	logic point_valid;
	logic point_ready;
	logic result_valid;
	logic result_ready;
	logic [cw-1:0] count;
	color_t color;

	escape_iterator #(
		.iter_max(iter_max)
	) iter_i (
		.clk(clk),
		.reset(reset),
		.point_valid(point_valid),
		.point_ready(point_ready),
		.c_re(c_re),
		.c_im(c_im),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.count(count)
	);

	color_map #(
		.iter_max(iter_max)
	) cmap_i (
		.count(count),
		.color(color)
	);

	// Handshakes decoded from state
	assign busy = (state != walk_idle);
	assign point_valid = (state == walk_issue);
	assign result_ready = (state == walk_wait_result);
	assign pixel_valid = (state == walk_write);
	assign last_pixel = (col == last_col) && (row == last_row);

	//////////////////////////////////////////////////////////////////////
	// Walk FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= walk_idle;
			frame_done <= 1'b0;
			col <= '0;
			row <= '0;
			pixel_addr <= '0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				walk_idle: begin
					// Start only counts here
					if (start) begin
						state <= walk_issue;
						col <= '0;
						row <= '0;
						pixel_addr <= '0;
					end
				end
				walk_issue: begin
					if (point_ready) begin
						state <= walk_wait_result;
					end
				end
				walk_wait_result: begin
					if (result_valid) begin
						state <= walk_write;
					end
				end
				walk_write: begin
					// Stall here while the frame buffer is busy
					if (pixel_ready) begin
						if (last_pixel) begin
							state <= walk_idle;
							frame_done <= 1'b1;
						end else begin
							state <= walk_issue;
							pixel_addr <= pixel_addr + 1'b1;
							if (col == last_col) begin
								col <= '0;
								row <= row + 1'b1;
							end else begin
								col <= col + 1'b1;
							end
						end
					end
				end
				default: begin
					state <= walk_idle;
				end
			endcase
		end
	end

	// Coordinate stepping and colour capture
	always_ff @(posedge clk) begin
		if (state == walk_idle && start) begin
			x_start_q <= x_start;
			inc_q <= pixel_increment;
			c_re <= x_start;
			c_im <= y_start;
		end else if (state == walk_write && pixel_ready && !last_pixel) begin
			// Row wrap reloads x and steps y down
			if (col == last_col) begin
				c_re <= x_start_q;
				c_im <= c_im - inc_q;
			end else begin
				c_re <= c_re + inc_q;
			end
		end
		if (state == walk_wait_result && result_valid) begin
			pixel_color <= color;
		end
	end

endmodule

// ==== hw/color_map.sv ====
`timescale 1ns/1ps

module color_map import mandel_pkg::*; #(
	parameter int iter_max = 1000
) (
	input  logic [$clog2(iter_max):0] count,
	output color_t color
);

	localparam int cw = $clog2(iter_max) + 1;

	// Band lower bounds, halving from the limit
	localparam logic [cw-1:0] lim [0:7] = '{
		cw'(iter_max),
		cw'(iter_max >> 1),
		cw'(iter_max >> 2),
		cw'(iter_max >> 3),
		cw'(iter_max >> 4),
		cw'(iter_max >> 5),
		cw'(iter_max >> 6),
		cw'(iter_max >> 7)
	};

	// Priority chain, band 0 first
	always_comb begin
		if (count >= lim[0]) begin
			color = colour_band_0;
		end else if (count >= lim[1]) begin
			color = colour_band_1;
		end else if (count >= lim[2]) begin
			color = colour_band_2;
		end else if (count >= lim[3]) begin
			color = colour_band_3;
		end else if (count >= lim[4]) begin
			color = colour_band_4;
		end else if (count >= lim[5]) begin
			color = colour_band_5;
		end else if (count >= lim[6]) begin
			color = colour_band_6;
		end else if (count >= lim[7]) begin
			color = colour_band_7;
		end else begin
			// Fast escapes
			color = colour_band_8;
		end
	end

endmodule

// ==== hw/escape_iterator.sv ====
`timescale 1ns/1ps

module escape_iterator import mandel_pkg::*; #(
	parameter int iter_max = 1000
) (
	input  logic clk,
	input  logic reset,

	// Point in
	input  logic point_valid,
	output logic point_ready,
	input  fix_t c_re,
	input  fix_t c_im,

	// Step count out
	output logic result_valid,
	input  logic result_ready,
	output logic [$clog2(iter_max):0] count
);

	// Count width, one spare bit above iter_max
	localparam int cw = $clog2(iter_max) + 1;
	localparam logic [cw-1:0] count_limit = cw'(iter_max);

	iter_state_t state;

	// Point under test and the running z
	fix_t c_re_q;
	fix_t c_im_q;
	fix_t zr;
	fix_t zi;

	// One step worth of combinational math
	fix_t zr_sq;
	fix_t zi_sq;
	fix_t zr_zi;
	fix_t mag_sq;
	fix_t next_re;
	fix_t next_im;
	logic escape;

	logic accept;

	//////////////////////////////////////////////////////////////////////
	// Fixed-point multiply
	//////////////////////////////////////////////////////////////////////

	// Full 54-bit product, keep sign plus bits 48..23
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [53:0] prod;
		prod = a * b;
		return {prod[53], prod[48:frac_bits]};
	endfunction

	always_comb begin
		zr_sq = fix_mul(zr, zr);
		zi_sq = fix_mul(zi, zi);
		zr_zi = fix_mul(zr, zi);
		// All sums wrap at 27 bits
		next_re = zr_sq - zi_sq + c_re_q;
		next_im = (zr_zi <<< 1) + c_im_q;
		mag_sq = zr_sq + zi_sq;
		// Escape on magnitude, on either component leaving +-2, or on the limit
		escape = (mag_sq > escape_mag_sq)
			|| (next_re > escape_coord) || (next_re < -escape_coord)
			|| (next_im > escape_coord) || (next_im < -escape_coord)
			|| (count == count_limit);
	end

	assign accept = point_valid && point_ready;

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= iter_idle;
			point_ready <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			case (state)
				iter_idle: begin
					if (accept) begin
						state <= iter_calc;
						point_ready <= 1'b0;
					end else begin
						// Comes up one cycle after reset
						point_ready <= 1'b1;
					end
				end
				iter_calc: begin
					// Escaping step still counts
					if (escape) begin
						state <= iter_done;
						result_valid <= 1'b1;
					end
				end
				iter_done: begin
					// Hold count until the walker takes it
					if (result_ready) begin
						state <= iter_idle;
						result_valid <= 1'b0;
						point_ready <= 1'b1;
					end
				end
				default: begin
					state <= iter_idle;
				end
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk) begin
		if (state == iter_idle && accept) begin
			c_re_q <= c_re;
			c_im_q <= c_im;
			zr <= '0;
			zi <= '0;
			count <= '0;
		end else if (state == iter_calc) begin
			zr <= next_re;
			zi <= next_im;
			count <= count + 1'b1;
		end
	end

endmodule

// ==== hw/mandel_pkg.sv ====
package mandel_pkg;

	//////////////////////////////////////////////////////////////////////
	// Fixed-point format
	//////////////////////////////////////////////////////////////////////

	// 4.23 signed, sign bit included in the 4 integer bits
	typedef logic signed [26:0] fix_t;

	// Fraction bit count, product slice starts here
	localparam int frac_bits = 23;

	// Squared magnitude bound of 4.0
	localparam fix_t escape_mag_sq = 27'sh2000000;
	// Bound of 2.0 on either component
	localparam fix_t escape_coord = 27'sh1000000;

	//////////////////////////////////////////////////////////////////////
	// Colour and palette
	//////////////////////////////////////////////////////////////////////

	// RRR GGG BB
	typedef logic [7:0] color_t;

	// Band 0 is the set itself, black
	localparam color_t colour_band_0 = 8'b000_000_00;
	localparam color_t colour_band_1 = 8'b011_001_00;
	localparam color_t colour_band_2 = 8'b011_001_00;
	localparam color_t colour_band_3 = 8'b101_010_01;
	localparam color_t colour_band_4 = 8'b011_001_01;
	localparam color_t colour_band_5 = 8'b001_001_01;
	localparam color_t colour_band_6 = 8'b011_010_10;
	// Outer bands share one colour
	localparam color_t colour_band_7 = 8'b010_100_10;
	localparam color_t colour_band_8 = 8'b010_100_10;

	//////////////////////////////////////////////////////////////////////
	// FSM states
	//////////////////////////////////////////////////////////////////////

	// Escape iterator
	typedef enum logic [1:0] {iter_idle, iter_calc, iter_done} iter_state_t;

	// Raster walker
	typedef enum logic [1:0] {walk_idle, walk_issue, walk_wait_result, walk_write} walk_state_t;

endpackage
